//--- source/dmatch_defines.svh
`ifndef DMATCH_DEFINES_SVH
`define DMATCH_DEFINES_SVH

// Number of implemented data breakpoints, 1 to 15.
`define DMATCH_NUM_DBRK 4

// Register codes inside one breakpoint slot.
`define DMATCH_OFS_ADDR 2'd0
`define DMATCH_OFS_CTRL 2'd1
`define DMATCH_OFS_AMASK 2'd2
`define DMATCH_OFS_DATA 2'd3

// Control word layout as seen by the host.
`define DMATCH_CTRL_BE_BIT 0
`define DMATCH_CTRL_TE_BIT 2
`define DMATCH_CTRL_BLM_LSB 4

`endif

//--- source/dmatch_pkg.sv
package dmatch_pkg;

  // One host register access.
  typedef struct packed {
    logic [5:0]  reg_addr;
    logic [31:0] wdata;
    logic        write;
    logic        strobe;
    logic        sel_status;
    logic        sel_regs;
  } host_req_t;

  // Store seen at writeback, word address.
  typedef struct packed {
    logic        valid;
    logic [29:0] addr;
    logic [31:0] data;
  } store_sample_t;

  typedef struct packed {
    logic       break_en;
    logic       trace_en;
    logic [3:0] byte_ignore;
  } dbrk_ctrl_t;

  // A set amask bit ignores that address bit.
  typedef struct packed {
    logic [29:0] addr;
    logic [29:0] amask;
    logic [31:0] data;
    dbrk_ctrl_t  ctrl;
  } dbrk_entry_t;

  // Exception-control strobes from the coprocessor.
  typedef struct packed {
    logic first_exc_if_break;
    logic first_exc_if_nobreak;
    logic pend_clear;
    logic pend_set_on_break;
    logic commit_on_break;
    logic commit_pending;
  } cp0_dbrk_t;

endpackage

//--- source/dmatch_reset_sync.sv
`timescale 1ns/1ns

module dmatch_reset_sync (
  input  logic CORE_CLOCK,
  input  logic arst_n,
  input  logic test_mode,
  output logic rst_n
);

  logic [1:0] sync_q;

  // Assert at once, release after two clock edges.
  always_ff @(posedge CORE_CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Scan test drives the raw reset straight through.
  assign rst_n = test_mode ? arst_n : sync_q[1];

endmodule

//--- source/dbrk_regfile.sv
`timescale 1ns/1ns
`include "dmatch_defines.svh"

module dbrk_regfile
  import dmatch_pkg::*;
(
  input  logic                                CORE_CLOCK,
  input  logic                                rst_n,
  input  host_req_t                           req,
  input  logic [`DMATCH_NUM_DBRK-1:0]         status_vec,
  output dbrk_entry_t [`DMATCH_NUM_DBRK-1:0]  entries,
  output logic [31:0]                         rdata
);

  logic [3:0]  idx;
  logic [1:0]  ofs;
  logic        idx_ok;
  logic        wr_en;
  dbrk_entry_t sel_entry;

  assign idx    = req.reg_addr[5:2];
  assign ofs    = req.reg_addr[1:0];
  assign idx_ok = idx < 4'(`DMATCH_NUM_DBRK);

  // Writes to unimplemented breakpoints are dropped.
  assign wr_en = req.strobe & req.write & req.sel_regs & idx_ok;

  always_ff @(posedge CORE_CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `DMATCH_NUM_DBRK; i++) begin
        entries[i] <= '0;
      end
    end else if (wr_en) begin
      for (int i = 0; i < `DMATCH_NUM_DBRK; i++) begin
        if (idx == 4'(i)) begin
          case (ofs)
            `DMATCH_OFS_ADDR: begin
              entries[i].addr <= req.wdata[31:2];
            end
            `DMATCH_OFS_CTRL: begin
              entries[i].ctrl.break_en    <= req.wdata[`DMATCH_CTRL_BE_BIT];
              entries[i].ctrl.trace_en    <= req.wdata[`DMATCH_CTRL_TE_BIT];
              entries[i].ctrl.byte_ignore <= req.wdata[`DMATCH_CTRL_BLM_LSB +: 4];
            end
            `DMATCH_OFS_AMASK: begin
              entries[i].amask <= req.wdata[31:2];
            end
            default: begin
              entries[i].data <= req.wdata;
            end
          endcase
        end
      end
    end
  end

  // Pick the addressed breakpoint for readback.
  always_comb begin
    sel_entry = '0;
    for (int i = 0; i < `DMATCH_NUM_DBRK; i++) begin
      if (idx == 4'(i)) begin
        sel_entry = entries[i];
      end
    end
  end

  always_comb begin
    rdata = '0;
    if (req.sel_regs) begin
      if (idx_ok) begin
        case (ofs)
          `DMATCH_OFS_ADDR: begin
            rdata = {sel_entry.addr, 2'b00};
          end
          `DMATCH_OFS_CTRL: begin
            rdata[`DMATCH_CTRL_BE_BIT]        = sel_entry.ctrl.break_en;
            rdata[`DMATCH_CTRL_TE_BIT]        = sel_entry.ctrl.trace_en;
            rdata[`DMATCH_CTRL_BLM_LSB +: 4]  = sel_entry.ctrl.byte_ignore;
          end
          `DMATCH_OFS_AMASK: begin
            rdata = {sel_entry.amask, 2'b00};
          end
          default: begin
            rdata = sel_entry.data;
          end
        endcase
      end
    end else begin
      // Status word carries the breakpoint count in 27:24.
      rdata[27:24]                 = 4'(`DMATCH_NUM_DBRK);
      rdata[`DMATCH_NUM_DBRK-1:0]  = status_vec;
    end
  end

endmodule

//--- source/dbrk_match.sv
`timescale 1ns/1ns
`include "dmatch_defines.svh"

module dbrk_match
  import dmatch_pkg::*;
(
  input  store_sample_t                       sample,
  input  dbrk_entry_t [`DMATCH_NUM_DBRK-1:0]  entries,
  output logic [`DMATCH_NUM_DBRK-1:0]         hit_vec,
  output logic                                break_hit,
  output logic                                trace_hit
);

  logic [`DMATCH_NUM_DBRK-1:0] addr_ok;
  logic [`DMATCH_NUM_DBRK-1:0] data_ok;
  logic [`DMATCH_NUM_DBRK-1:0] be_vec;
  logic [`DMATCH_NUM_DBRK-1:0] te_vec;

  always_comb begin
    for (int i = 0; i < `DMATCH_NUM_DBRK; i++) begin
      // Masked bits always compare equal.
      addr_ok[i] = &((sample.addr ~^ entries[i].addr) | entries[i].amask);

      data_ok[i] = 1'b1;
      for (int b = 0; b < 4; b++) begin
        if (!entries[i].ctrl.byte_ignore[b] &&
            (sample.data[8*b +: 8] != entries[i].data[8*b +: 8])) begin
          data_ok[i] = 1'b0;
        end
      end

      hit_vec[i] = sample.valid & addr_ok[i] & data_ok[i];
      be_vec[i]  = entries[i].ctrl.break_en;
      te_vec[i]  = entries[i].ctrl.trace_en;
    end
  end

  assign break_hit = |(hit_vec & be_vec);
  assign trace_hit = |(hit_vec & te_vec);

endmodule

//--- source/dbrk_status.sv
`timescale 1ns/1ns
`include "dmatch_defines.svh"

module dbrk_status
  import dmatch_pkg::*;
(
  input  logic                         CORE_CLOCK,
  input  logic                         rst_n,
  input  cp0_dbrk_t                    cp0,
  input  logic [`DMATCH_NUM_DBRK-1:0]  hit_vec,
  input  logic                         break_hit,
  input  host_req_t                    req,
  output logic [`DMATCH_NUM_DBRK-1:0]  status_vec
);

  logic                         first_exc;
  logic                         status_wr;
  logic [`DMATCH_NUM_DBRK-1:0]  pend_r;
  logic [`DMATCH_NUM_DBRK-1:0]  hit_r;
  logic [`DMATCH_NUM_DBRK-1:0]  status_r;

  // The exception unit qualifies commits by whether a break is taken.
  assign first_exc = break_hit ? cp0.first_exc_if_break : cp0.first_exc_if_nobreak;
  assign status_wr = req.strobe & req.write & req.sel_status;

  always_ff @(posedge CORE_CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      pend_r   <= '0;
      hit_r    <= '0;
      status_r <= '0;
    end else begin
      if (cp0.pend_clear) begin
        pend_r <= '0;
      end else if (cp0.pend_set_on_break && break_hit) begin
        pend_r <= hit_vec;
      end

      if (first_exc) begin
        if (cp0.commit_on_break) begin
          hit_r <= hit_vec;
        end else if (cp0.commit_pending) begin
          hit_r <= pend_r;
        end
      end

      // Sticky bits clear only on a host write.
      if (status_wr) begin
        status_r <= req.wdata[`DMATCH_NUM_DBRK-1:0];
      end else begin
        status_r <= status_r | hit_r;
      end
    end
  end

  assign status_vec = status_r;

endmodule

//--- source/ejtag_dmatch_top.sv
`timescale 1ns/1ns
`include "dmatch_defines.svh"

module ejtag_dmatch_top
  import dmatch_pkg::*;
(
  input  logic          CORE_CLOCK,
  input  logic          arst_n,
  input  logic          test_mode,
  input  host_req_t     req,
  input  store_sample_t sample,
  input  cp0_dbrk_t     cp0,
  output logic [31:0]   rdata,
  output logic          break_hit,
  output logic          trace_hit
);

  logic                                rst_n;
  dbrk_entry_t [`DMATCH_NUM_DBRK-1:0]  entries;
  logic [`DMATCH_NUM_DBRK-1:0]         hit_vec;
  logic [`DMATCH_NUM_DBRK-1:0]         status_vec;

  dmatch_reset_sync u_reset_sync (
    .CORE_CLOCK (CORE_CLOCK),
    .arst_n     (arst_n),
    .test_mode  (test_mode),
    .rst_n      (rst_n)
  );

  dbrk_regfile u_regfile (
    .CORE_CLOCK (CORE_CLOCK),
    .rst_n      (rst_n),
    .req        (req),
    .status_vec (status_vec),
    .entries    (entries),
    .rdata      (rdata)
  );

  dbrk_match u_match (
    .sample    (sample),
    .entries   (entries),
    .hit_vec   (hit_vec),
    .break_hit (break_hit),
    .trace_hit (trace_hit)
  );

  dbrk_status u_status (
    .CORE_CLOCK (CORE_CLOCK),
    .rst_n      (rst_n),
    .cp0        (cp0),
    .hit_vec    (hit_vec),
    .break_hit  (break_hit),
    .req        (req),
    .status_vec (status_vec)
  );

endmodule

//--- tb/dmatch_assertions.sv
`timescale 1ns/1ns
`include "dmatch_defines.svh"

module dmatch_assertions
  import dmatch_pkg::*;
(
  input logic          CORE_CLOCK,
  input logic          rst_n,
  input host_req_t     req,
  input store_sample_t sample,
  input logic [31:0]   rdata,
  input logic          break_hit,
  input logic          trace_hit
);

  int fail_count = 0;

  // No store sample means no hit.
  no_hit_when_idle: assert property (@(posedge CORE_CLOCK) disable iff (!rst_n)
    !sample.valid |-> !break_hit && !trace_hit)
    else begin
      fail_count++;
      $error("break_hit or trace_hit high without a valid store sample");
    end

  // Unused control bits read as zero.
  ctrl_read_reserved_zero: assert property (@(posedge CORE_CLOCK) disable iff (!rst_n)
    req.sel_regs && (req.reg_addr[1:0] == `DMATCH_OFS_CTRL) |-> !rdata[3] && !rdata[1])
    else begin
      fail_count++;
      $error("control register read shows a reserved bit set");
    end

  no_hit_in_reset: assert property (@(posedge CORE_CLOCK)
    !rst_n |-> !break_hit && !trace_hit)
    else begin
      fail_count++;
      $error("break_hit or trace_hit high during reset");
    end

endmodule

bind ejtag_dmatch_top dmatch_assertions u_assertions (
  .CORE_CLOCK (CORE_CLOCK),
  .rst_n      (rst_n),
  .req        (req),
  .sample     (sample),
  .rdata      (rdata),
  .break_hit  (break_hit),
  .trace_hit  (trace_hit)
);

//--- tb/dmatch_tb.sv
`timescale 1ns/1ns
`include "dmatch_defines.svh"

module dmatch_tb
  import dmatch_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int NB = `DMATCH_NUM_DBRK;
  localparam logic [31:0] CTRL_MASK = 32'h0000_00F5;
  // Reset, readback, then five tests that each reprogram every breakpoint.
  localparam int TEST_CYCLES = 20 + (NB * 13 + 4) + 5 * (NB * 8 + 30);

  localparam cp0_dbrk_t CP0_NONE = '0;
  localparam cp0_dbrk_t CP0_COMMIT_BREAK =
    '{first_exc_if_break: 1'b1, commit_on_break: 1'b1, default: 1'b0};
  localparam cp0_dbrk_t CP0_FLUSH =
    '{first_exc_if_nobreak: 1'b1, commit_on_break: 1'b1, default: 1'b0};
  localparam cp0_dbrk_t CP0_PEND_SET = '{pend_set_on_break: 1'b1, default: 1'b0};
  localparam cp0_dbrk_t CP0_PEND_CLEAR = '{pend_clear: 1'b1, default: 1'b0};
  localparam cp0_dbrk_t CP0_COMMIT_PEND =
    '{first_exc_if_nobreak: 1'b1, commit_pending: 1'b1, default: 1'b0};

  logic          CORE_CLOCK;
  logic          arst_n;
  logic          test_mode;
  host_req_t     req;
  store_sample_t sample;
  cp0_dbrk_t     cp0;
  logic [31:0]   rdata;
  logic          break_hit;
  logic          trace_hit;
  int            errors;
  logic [31:0]   rng;

  ejtag_dmatch_top dut_i (.*);

  always #(CLK_PERIOD / 2) CORE_CLOCK = ~CORE_CLOCK;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %08h, actual %08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_hits(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: expected break/trace %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_status(input string name, input logic [NB-1:0] exp,
                              input logic [NB-1:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: expected status %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic host_write(input logic regs, input logic [5:0] addr, input logic [31:0] wdata);
    @(negedge CORE_CLOCK);
    req = '{reg_addr: addr, wdata: wdata, write: 1'b1, strobe: 1'b1,
            sel_status: ~regs, sel_regs: regs};
    @(negedge CORE_CLOCK);
    req.strobe = 1'b0;
    req.write  = 1'b0;
  endtask

  task automatic host_read(input logic regs, input logic [5:0] addr, output logic [31:0] data);
    @(negedge CORE_CLOCK);
    req = '{reg_addr: addr, wdata: 32'h0, write: 1'b0, strobe: 1'b1,
            sel_status: 1'b0, sel_regs: regs};
    #(CLK_PERIOD / 4);
    data = rdata;
  endtask

  task automatic program_bp(input int idx, input logic [31:0] addr, input logic [31:0] amask,
                            input logic [31:0] data, input logic [31:0] ctrl);
    host_write(1'b1, {4'(idx), `DMATCH_OFS_ADDR}, addr);
    host_write(1'b1, {4'(idx), `DMATCH_OFS_AMASK}, amask);
    host_write(1'b1, {4'(idx), `DMATCH_OFS_DATA}, data);
    host_write(1'b1, {4'(idx), `DMATCH_OFS_CTRL}, ctrl);
  endtask

  task automatic clear_all();
    for (int i = 0; i < NB; i++) begin
      program_bp(i, 32'h0, 32'h0, 32'h0, 32'h0);
    end
  endtask

  // Drives one core cycle and samples the hits in its middle.
  task automatic core_cycle(input logic valid, input logic [31:0] addr, input logic [31:0] data,
                            input cp0_dbrk_t strobes, output logic [1:0] hits);
    @(negedge CORE_CLOCK);
    sample = '{valid: valid, addr: addr[31:2], data: data};
    cp0    = strobes;
    #(CLK_PERIOD / 4);
    hits = {break_hit, trace_hit};
    @(negedge CORE_CLOCK);
    sample.valid = 1'b0;
    cp0          = CP0_NONE;
  endtask

  task automatic test_readback();
    logic [31:0] v;
    logic [31:0] exp;
    logic [31:0] got;
    logic [31:0] data_exp [NB];
    for (int i = 0; i < NB; i++) begin
      for (int o = 0; o < 4; o++) begin
        rng = xorshift32(rng);
        v   = rng;
        host_write(1'b1, {4'(i), 2'(o)}, v);
        host_read(1'b1, {4'(i), 2'(o)}, got);
        case (2'(o))
          `DMATCH_OFS_CTRL: exp = v & CTRL_MASK;
          `DMATCH_OFS_DATA: begin
            exp         = v;
            data_exp[i] = v;
          end
          default:          exp = v & 32'hFFFF_FFFC;
        endcase
        check_word("register readback", exp, got);
      end
    end
    host_write(1'b1, {4'(NB), `DMATCH_OFS_DATA}, 32'hDEAD_BEEF);
    host_read(1'b1, {4'(NB), `DMATCH_OFS_DATA}, got);
    check_word("unimplemented index", 32'h0, got);
    // Implemented data registers keep their values.
    for (int i = 0; i < NB; i++) begin
      host_read(1'b1, {4'(i), `DMATCH_OFS_DATA}, got);
      check_word("unimplemented write ignored", data_exp[i], got);
    end
  endtask

  task automatic test_addr_mask();
    logic [1:0] hits;
    clear_all();
    program_bp(0, 32'h1000_0040, 32'h0000_00F0, 32'h0, 32'h0000_00F1);
    core_cycle(1'b1, 32'h1000_0070, 32'h1234_5678, CP0_NONE, hits);
    check_hits("address masked bits", 2'b10, hits);
    core_cycle(1'b1, 32'h1000_0140, 32'h1234_5678, CP0_NONE, hits);
    check_hits("address unmasked bit", 2'b00, hits);
  endtask

  task automatic test_byte_lanes();
    logic [1:0]  hits;
    logic [31:0] d;
    rng = xorshift32(rng);
    d   = rng;
    clear_all();
    // Lanes 0 and 2 ignored.
    program_bp(0, 32'h2000_0100, 32'h0, d, 32'h0000_0051);
    core_cycle(1'b1, 32'h2000_0100, d ^ 32'h00FF_00FF, CP0_NONE, hits);
    check_hits("data ignored lanes", 2'b10, hits);
    core_cycle(1'b1, 32'h2000_0100, d ^ 32'h0000_FF00, CP0_NONE, hits);
    check_hits("data compared lane", 2'b00, hits);
  endtask

  task automatic test_break_trace();
    logic [1:0] hits;
    clear_all();
    program_bp(0, 32'h3000_0000, 32'h0, 32'h0, 32'h0000_00F1);
    program_bp(1 % NB, 32'h3000_0000, 32'h0, 32'h0, 32'h0000_00F4);
    core_cycle(1'b1, 32'h3000_0000, 32'hCAFE_0001, CP0_NONE, hits);
    check_hits("break and trace", (NB > 1) ? 2'b11 : 2'b01, hits);
    core_cycle(1'b0, 32'h3000_0000, 32'hCAFE_0001, CP0_NONE, hits);
    check_hits("valid low", 2'b00, hits);
  endtask

  task automatic test_direct_commit();
    logic [1:0]  hits;
    logic [31:0] word;
    clear_all();
    program_bp(NB - 1, 32'h4000_0080, 32'h0, 32'h0, 32'h0000_00F1);
    core_cycle(1'b1, 32'h4000_0080, 32'h1, CP0_COMMIT_BREAK, hits);
    check_hits("direct commit hit", 2'b10, hits);
    host_read(1'b0, 6'd0, word);
    check_status("direct commit", NB'(1) << (NB - 1), word[NB-1:0]);
    check_word("status count field", 32'(NB) << 24, word & 32'h0F00_0000);
    // The hit register holds until the next commit.
    core_cycle(1'b0, 32'h0, 32'h0, CP0_FLUSH, hits);
    host_write(1'b0, 6'd0, 32'h0);
    host_read(1'b0, 6'd0, word);
    check_status("status write clear", '0, word[NB-1:0]);
  endtask

  task automatic test_pending();
    logic [1:0]  hits;
    logic [31:0] word;
    clear_all();
    program_bp(0, 32'h5000_0000, 32'h0, 32'h0, 32'h0000_00F1);
    core_cycle(1'b1, 32'h5000_0000, 32'h77, CP0_PEND_SET, hits);
    check_hits("pending set hit", 2'b10, hits);
    core_cycle(1'b0, 32'h0, 32'h0, CP0_COMMIT_PEND, hits);
    host_read(1'b0, 6'd0, word);
    check_status("pending commit", NB'(1), word[NB-1:0]);
    core_cycle(1'b0, 32'h0, 32'h0, CP0_FLUSH, hits);
    host_write(1'b0, 6'd0, 32'h0);
    core_cycle(1'b1, 32'h5000_0000, 32'h77, CP0_PEND_SET, hits);
    check_hits("pending set again hit", 2'b10, hits);
    core_cycle(1'b0, 32'h0, 32'h0, CP0_PEND_CLEAR, hits);
    core_cycle(1'b0, 32'h0, 32'h0, CP0_COMMIT_PEND, hits);
    host_read(1'b0, 6'd0, word);
    check_status("pending cleared", '0, word[NB-1:0]);
  endtask

  initial begin
    #(TEST_CYCLES * 2 * CLK_PERIOD);
    $display("Timeout after %0d cycles, the tests did not finish", TEST_CYCLES * 2);
    $display("Errors found");
    $finish;
  end

  initial begin
    CORE_CLOCK = 1'b0;
    arst_n     = 1'b0;
    test_mode  = 1'b0;
    req        = '0;
    sample     = '0;
    cp0        = CP0_NONE;
    errors     = 0;
    rng        = 32'd25;
    repeat (16) @(negedge CORE_CLOCK);
    arst_n = 1'b1;
    repeat (3) @(negedge CORE_CLOCK);
    test_readback();
    test_addr_mask();
    test_byte_lanes();
    test_break_trace();
    test_direct_commit();
    test_pending();
    $display("Summary: %0d check errors, %0d assertion failures",
             errors, dut_i.u_assertions.fail_count);
    if (errors == 0 && dut_i.u_assertions.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+source
source/dmatch_pkg.sv
source/dmatch_reset_sync.sv
source/dbrk_regfile.sv
source/dbrk_match.sv
source/dbrk_status.sv
source/ejtag_dmatch_top.sv
tb/dmatch_assertions.sv
tb/dmatch_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dmatch_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
